//--- rtl/epb_opb_cfg.svh
`ifndef EPB_OPB_CFG_SVH
`define EPB_OPB_CFG_SVH

// cycles of select without acknowledge before the arbiter gives up
`define EPB_OPB_TIMEOUT_CYCLES 16

// block RAM size in 32-bit words, and extra cycles before it answers
`define EPB_OPB_RAM_DEPTH 256
`define EPB_OPB_RAM_WAIT 2

// register bank, word 0 is the read-only identity
`define EPB_OPB_REG_COUNT 8
`define EPB_OPB_ID 32'h0E5B_0B01

// gp windows in the address map
`define EPB_OPB_GP_REG 3'd0
`define EPB_OPB_GP_RAM 3'd1

`endif

//--- rtl/epb_opb_pkg.sv
`default_nettype none

package epb_opb_pkg;

  // ********************
  // OPB bus types
  // ********************

  // master to bus, bit 0 is the most significant as on OPB
  typedef struct packed {
    logic        select;
    logic        rnw;
    logic [0:3]  be;
    logic [0:31] abus;
    logic [0:31] dbus;
  } opb_mreq_t;

  // slave to bus, all-zero when the slave is not addressed
  typedef struct packed {
    logic        xfer_ack;
    logic        err_ack;
    logic        retry;
    logic [0:31] dbus;
  } opb_sresp_t;

  // ********************
  // bridge FSM
  // ********************

  typedef enum logic [1:0] {
    st_idle,
    st_arb,
    st_wait
  } bridge_state_t;

  // top five address bits are always zero, then the three gp bits
  function automatic logic opb_window_hit(input logic [0:31] abus, input logic [2:0] gp);
    logic upper_clear;
    upper_clear = (abus[0:4] == 5'b0);
    return upper_clear && (abus[5:7] == gp);
  endfunction

endpackage

`default_nettype wire

//--- rtl/opb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "epb_opb_cfg.svh"

module opb_arbiter (
  input  wire                         OPB_Clk,
  input  wire                         reset,
  input  wire                         request,
  output logic                        grant,
  input  wire epb_opb_pkg::opb_mreq_t mreq,
  input  wire                         ack_seen,
  output logic                        timeout
);

  localparam int CNT_W = $clog2(`EPB_OPB_TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] wd_cnt;

  // ********************
  // grant
  // ********************

  // one master, so the grant simply follows its request a cycle later
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      grant <= 1'b0;
    end else begin
      grant <= request;
    end
  end

  // ********************
  // timeout watchdog
  // ********************

  // counts select cycles with no acknowledge, timeout is a single pulse
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      wd_cnt  <= '0;
      timeout <= 1'b0;
    end else if (mreq.select && !ack_seen && !timeout) begin
      wd_cnt  <= wd_cnt + 1'b1;
      timeout <= (wd_cnt == CNT_W'(`EPB_OPB_TIMEOUT_CYCLES - 1));
    end else begin
      // transfer over or select dropped
      wd_cnt  <= '0;
      timeout <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/opb_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "epb_opb_cfg.svh"

module opb_reg_slave (
  input  wire                         OPB_Clk,
  input  wire                         reset,
  input  wire epb_opb_pkg::opb_mreq_t mreq,
  output epb_opb_pkg::opb_sresp_t     sresp
);
  import epb_opb_pkg::*;

  localparam int IDX_W = $clog2(`EPB_OPB_REG_COUNT);

  // word 0 is the identity constant and has no storage
  logic [31:0]      regs [1:`EPB_OPB_REG_COUNT-1];
  logic [31:0]      rdata;
  logic [31:0]      wdata;
  logic [IDX_W-1:0] idx;
  logic             hit;
  logic             busy;
  logic             xfer_ack_r;
  logic             err_ack_r;

  assign hit   = mreq.select && opb_window_hit(mreq.abus, `EPB_OPB_GP_REG);
  assign idx   = mreq.abus[30-IDX_W +: IDX_W];
  assign wdata = mreq.dbus;
  assign busy  = xfer_ack_r || err_ack_r;

  // ********************
  // register writes and acks
  // ********************

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      xfer_ack_r <= 1'b0;
      err_ack_r  <= 1'b0;
      for (int i = 1; i < `EPB_OPB_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      xfer_ack_r <= 1'b0;
      err_ack_r  <= 1'b0;
      if (hit && !busy) begin
        if (!mreq.rnw && idx == '0) begin
          // identity word is read-only
          err_ack_r <= 1'b1;
        end else begin
          xfer_ack_r <= 1'b1;
          if (!mreq.rnw) begin
            for (int b = 0; b < 4; b++) begin
              if (mreq.be[b]) begin
                regs[idx][31-8*b -: 8] <= wdata[31-8*b -: 8];
              end
            end
          end
        end
      end
    end
  end

  // read word captured together with the ack
  always_ff @(posedge OPB_Clk) begin
    if (hit && !busy) begin
      rdata <= (idx == '0) ? `EPB_OPB_ID : regs[idx];
    end
  end

  assign sresp = '{
    xfer_ack: xfer_ack_r,
    err_ack:  err_ack_r,
    retry:    1'b0,
    dbus:     (xfer_ack_r && mreq.rnw) ? rdata : 32'b0
  };

endmodule

`default_nettype wire

//--- rtl/opb_ram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "epb_opb_cfg.svh"

module opb_ram_slave (
  input  wire                         OPB_Clk,
  input  wire                         reset,
  input  wire epb_opb_pkg::opb_mreq_t mreq,
  output epb_opb_pkg::opb_sresp_t     sresp
);
  import epb_opb_pkg::*;

  localparam int ADDR_W = $clog2(`EPB_OPB_RAM_DEPTH);
  localparam int WAIT_W = $clog2(`EPB_OPB_RAM_WAIT + 2);

  logic [31:0]       mem [`EPB_OPB_RAM_DEPTH];
  logic [31:0]       rdata;
  logic [31:0]       wdata;
  logic [ADDR_W-1:0] waddr;
  logic [WAIT_W-1:0] wait_cnt;
  logic              hit;
  logic              done;
  logic              ack_r;

  assign hit   = mreq.select && opb_window_hit(mreq.abus, `EPB_OPB_GP_RAM);
  assign waddr = mreq.abus[30-ADDR_W +: ADDR_W];
  assign wdata = mreq.dbus;

  // last wait cycle, the access happens on this edge
  assign done = hit && !ack_r && (wait_cnt == WAIT_W'(`EPB_OPB_RAM_WAIT));

  // ********************
  // wait states
  // ********************

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      wait_cnt <= '0;
      ack_r    <= 1'b0;
    end else if (!hit || ack_r) begin
      // select fell or transfer finished, start over
      wait_cnt <= '0;
      ack_r    <= 1'b0;
    end else if (done) begin
      wait_cnt <= '0;
      ack_r    <= 1'b1;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // ********************
  // memory array
  // ********************

  always_ff @(posedge OPB_Clk) begin
    if (done) begin
      if (mreq.rnw) begin
        rdata <= mem[waddr];
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (mreq.be[b]) begin
            mem[waddr][31-8*b -: 8] <= wdata[31-8*b -: 8];
          end
        end
      end
    end
  end

  assign sresp = '{
    xfer_ack: ack_r,
    err_ack:  1'b0,
    retry:    1'b0,
    dbus:     (ack_r && mreq.rnw) ? rdata : 32'b0
  };

endmodule

`default_nettype wire

//--- rtl/epb_opb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module epb_opb_bridge (
  input  wire                          OPB_Clk,
  input  wire                          reset,
  input  wire                          epb_cs_n,
  input  wire                          epb_r_w_n,
  input  wire                          epb_oe_n,
  input  wire  [1:0]                   epb_be_n,
  input  wire  [22:0]                  epb_addr,
  input  wire  [5:0]                   epb_addr_gp,
  input  wire  [15:0]                  epb_data_i,
  output logic [15:0]                  epb_data_o,
  output logic                         epb_data_oe_n,
  output logic                         epb_rdy,
  output logic                         request,
  input  wire                          grant,
  output epb_opb_pkg::opb_mreq_t       mreq,
  input  wire epb_opb_pkg::opb_sresp_t sresp,
  input  wire                          timeout
);
  import epb_opb_pkg::*;

  bridge_state_t state;

  logic        prev_cs_n;
  logic        cs_strb;
  logic        epb_trans;
  logic        select_r;
  logic        select;
  logic        opb_reply;
  logic [0:3]  be;
  logic [0:31] abus;
  logic [0:31] dbus;

  // ********************
  // EPB side
  // ********************

  // registered copy of cs_n for the falling edge
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      prev_cs_n <= 1'b1;
    end else begin
      prev_cs_n <= epb_cs_n;
    end
  end

  assign cs_strb   = prev_cs_n && !epb_cs_n;
  assign epb_trans = !epb_cs_n;
  assign opb_reply = sresp.xfer_ack | sresp.err_ack | sresp.retry | timeout;

  // drive the host data pins only for a read with cs and oe low
  assign epb_data_oe_n = !epb_r_w_n || !epb_trans || epb_oe_n;

  // reply data comes straight off the bus
  assign epb_rdy    = (state == st_wait) && opb_reply;
  assign epb_data_o = epb_addr[0] ? sresp.dbus[16:31] : sresp.dbus[0:15];

  // ********************
  // OPB side
  // ********************

  assign request = (state == st_arb) || (state == st_wait) || cs_strb;

  // grant cuts straight through to select, saving a cycle
  assign select = select_r ||
                  ((state == st_idle) && cs_strb && grant) ||
                  ((state == st_arb) && grant);

  // halfword steering, address bit 0 picks the low lanes
  assign abus = {5'b0, epb_addr_gp[2:0], epb_addr[22:1], 2'b0};
  assign be   = epb_addr[0] ? {2'b00, !epb_be_n[1], !epb_be_n[0]}
                            : {!epb_be_n[1], !epb_be_n[0], 2'b00};
  assign dbus = epb_addr[0] ? {16'b0, epb_data_i} : {epb_data_i, 16'b0};

  assign mreq = '{
    select: select,
    rnw:    select ? epb_r_w_n : 1'b0,
    be:     select ? be : 4'b0,
    abus:   select ? abus : 32'b0,
    dbus:   select ? dbus : 32'b0
  };

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state    <= st_idle;
      select_r <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (cs_strb) begin
            if (grant) begin
              select_r <= 1'b1;
              state    <= st_wait;
            end else begin
              state <= st_arb;
            end
          end
        end
        st_arb: begin
          // host gave up before the bus was ours
          if (!epb_trans) begin
            state <= st_idle;
          end else if (grant) begin
            select_r <= 1'b1;
            state    <= st_wait;
          end
        end
        st_wait: begin
          if (!epb_trans || opb_reply) begin
            select_r <= 1'b0;
            state    <= st_idle;
          end
        end
        default: begin
          select_r <= 1'b0;
          state    <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/epb_opb_top.sv
`timescale 1ns/1ps
`default_nettype none

module epb_opb_top (
  input  wire         OPB_Clk,
  input  wire         reset,
  input  wire         epb_cs_n,
  input  wire         epb_r_w_n,
  input  wire         epb_oe_n,
  input  wire  [1:0]  epb_be_n,
  input  wire  [22:0] epb_addr,
  input  wire  [5:0]  epb_addr_gp,
  input  wire  [15:0] epb_data_i,
  output logic [15:0] epb_data_o,
  output logic        epb_data_oe_n,
  output logic        epb_rdy
);
  import epb_opb_pkg::*;

  opb_mreq_t  mreq;
  opb_sresp_t sresp_reg;
  opb_sresp_t sresp_ram;
  opb_sresp_t sresp_bus;
  logic       request;
  logic       grant;
  logic       timeout;
  logic       ack_seen;

  // unaddressed slaves drive zeros, so OR is the bus
  assign sresp_bus = opb_sresp_t'(sresp_reg | sresp_ram);
  assign ack_seen  = sresp_bus.xfer_ack | sresp_bus.err_ack | sresp_bus.retry;

  epb_opb_bridge u_bridge (
    .OPB_Clk       (OPB_Clk),
    .reset         (reset),
    .epb_cs_n      (epb_cs_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_oe_n      (epb_oe_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy),
    .request       (request),
    .grant         (grant),
    .mreq          (mreq),
    .sresp         (sresp_bus),
    .timeout       (timeout)
  );

  opb_arbiter u_arbiter (
    .OPB_Clk  (OPB_Clk),
    .reset    (reset),
    .request  (request),
    .grant    (grant),
    .mreq     (mreq),
    .ack_seen (ack_seen),
    .timeout  (timeout)
  );

  opb_reg_slave u_reg_slave (
    .OPB_Clk (OPB_Clk),
    .reset   (reset),
    .mreq    (mreq),
    .sresp   (sresp_reg)
  );

  opb_ram_slave u_ram_slave (
    .OPB_Clk (OPB_Clk),
    .reset   (reset),
    .mreq    (mreq),
    .sresp   (sresp_ram)
  );

endmodule

`default_nettype wire

//--- test/epb_opb_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "epb_opb_cfg.svh"

module epb_opb_assert (
  input wire                             OPB_Clk,
  input wire                             reset,
  input wire                             epb_cs_n,
  input wire                             epb_r_w_n,
  input wire                             epb_oe_n,
  input wire                             epb_data_oe_n,
  input wire                             epb_rdy,
  input wire epb_opb_pkg::bridge_state_t bridge_state
);
  import epb_opb_pkg::*;

  int unsigned fail_cnt;
  logic        cs_seen;

  initial begin
    fail_cnt = 0;
  end

  // set once the host has selected the bridge
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      cs_seen <= 1'b0;
    end else if (!epb_cs_n) begin
      cs_seen <= 1'b1;
    end
  end

  // ********************
  // pin protocol
  // ********************

  oe_matches_read: assert property (@(posedge OPB_Clk)
      epb_data_oe_n == !(epb_r_w_n && !epb_cs_n && !epb_oe_n))
    else begin
      fail_cnt++;
      $error("data output enable does not follow a host read");
    end

  no_rdy_while_deselected: assert property (@(posedge OPB_Clk) disable iff (reset)
      epb_cs_n |-> !epb_rdy)
    else begin
      fail_cnt++;
      $error("epb_rdy high while cs_n is high");
    end

  no_reply_before_select: assert property (@(posedge OPB_Clk) disable iff (reset)
      !cs_seen |-> !epb_rdy)
    else begin
      fail_cnt++;
      $error("reply seen before any chip select");
    end

  // every access ends in a reply or the host gives up
  rdy_within_bound: assert property (@(posedge OPB_Clk) disable iff (reset)
      $fell(epb_cs_n) |-> ##[1:`EPB_OPB_TIMEOUT_CYCLES + 4] (epb_rdy || epb_cs_n))
    else begin
      fail_cnt++;
      $error("epb_rdy did not arrive within the timeout bound");
    end

  // bridge back in idle once cs has stayed high for two samples
  idle_once_released: assert property (@(posedge OPB_Clk) disable iff (reset)
      (epb_cs_n && $past(epb_cs_n)) |-> (bridge_state == st_idle))
    else begin
      fail_cnt++;
      $error("bridge not idle after the host released cs");
    end

endmodule

bind epb_opb_top epb_opb_assert u_assert (
  .OPB_Clk       (OPB_Clk),
  .reset         (reset),
  .epb_cs_n      (epb_cs_n),
  .epb_r_w_n     (epb_r_w_n),
  .epb_oe_n      (epb_oe_n),
  .epb_data_oe_n (epb_data_oe_n),
  .epb_rdy       (epb_rdy),
  .bridge_state  (u_bridge.state)
);

`default_nettype wire

//--- test/epb_opb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "epb_opb_cfg.svh"

module epb_opb_tb;

  localparam int XFER_COUNT      = 11 + 4 * (`EPB_OPB_REG_COUNT - 1) + 5 + 2 + 2;
  localparam int WATCHDOG_CYCLES = XFER_COUNT * 30 + 200;
  localparam int RDY_LIMIT       = `EPB_OPB_TIMEOUT_CYCLES + 4;
  localparam logic [22:0] RAM_WORD    = 23'h000084;
  localparam logic [2:0]  GP_UNMAPPED = 3'd5;

  logic        OPB_Clk;
  logic        reset;
  logic        epb_cs_n;
  logic        epb_r_w_n;
  logic        epb_oe_n;
  logic [1:0]  epb_be_n;
  logic [22:0] epb_addr;
  logic [5:0]  epb_addr_gp;
  logic [15:0] epb_data_i;
  wire  [15:0] epb_data_o;
  wire         epb_data_oe_n;
  wire         epb_rdy;

  // halfword view of both slaves
  logic [15:0] ram_model [2*`EPB_OPB_RAM_DEPTH];
  logic [15:0] reg_model [2*`EPB_OPB_REG_COUNT];
  logic [15:0] exp_data;
  logic        rd_check;
  string       test_name;
  int          data_errs;
  int          rdy_errs;
  integer      seed;

  epb_opb_top uut (
    .OPB_Clk       (OPB_Clk),
    .reset         (reset),
    .epb_cs_n      (epb_cs_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_oe_n      (epb_oe_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n),
    .epb_rdy       (epb_rdy)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge OPB_Clk);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  // read data must match the model in the reply cycle
  read_data_check: assert property (@(posedge OPB_Clk) disable iff (reset)
      (epb_rdy && rd_check) |-> (epb_data_o == exp_data))
    else begin
      data_errs++;
      $display("[FAIL] %s: expected %h, actual %h", test_name, exp_data, $sampled(epb_data_o));
    end

  // ********************
  // reference model
  // ********************

  function automatic logic [15:0] next_rand();
    return 16'($random(seed));
  endfunction

  // be_n[1] guards the upper byte, be_n[0] the lower
  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
                                              input logic [1:0] be_n);
    logic [15:0] res;
    res = old;
    if (!be_n[1]) res[15:8] = data[15:8];
    if (!be_n[0]) res[7:0] = data[7:0];
    return res;
  endfunction

  function automatic logic [15:0] model_read(input logic [2:0] gp, input logic [22:0] addr);
    if (gp == `EPB_OPB_GP_REG) begin
      return reg_model[addr % (2 * `EPB_OPB_REG_COUNT)];
    end
    return ram_model[addr % (2 * `EPB_OPB_RAM_DEPTH)];
  endfunction

  task automatic model_write(input logic [2:0] gp, input logic [22:0] addr,
                             input logic [1:0] be_n, input logic [15:0] data);
    int idx;
    if (gp == `EPB_OPB_GP_REG) begin
      idx = addr % (2 * `EPB_OPB_REG_COUNT);
      // identity word keeps its value
      if (idx >= 2) reg_model[idx] = merge_bytes(reg_model[idx], data, be_n);
    end else if (gp == `EPB_OPB_GP_RAM) begin
      idx = addr % (2 * `EPB_OPB_RAM_DEPTH);
      ram_model[idx] = merge_bytes(ram_model[idx], data, be_n);
    end
  endtask

  // ********************
  // EPB host
  // ********************

  task automatic run_transfer(input logic rnw, input logic [2:0] gp, input logic [22:0] addr,
                              input logic [1:0] be_n, input logic [15:0] data);
    int waited;
    waited      = 0;
    epb_addr_gp = {3'b0, gp};
    epb_addr    = addr;
    epb_be_n    = be_n;
    epb_data_i  = data;
    epb_r_w_n   = rnw;
    epb_oe_n    = !rnw;
    epb_cs_n    = 1'b0;
    @(posedge OPB_Clk);
    #1;
    while (!epb_rdy && waited < RDY_LIMIT) begin
      @(posedge OPB_Clk);
      #1;
      waited++;
    end
    if (!epb_rdy) begin
      rdy_errs++;
      $display("%s: no epb_rdy within %0d cycles of the cs fall", test_name, RDY_LIMIT);
    end
    // keep cs low through the reply edge
    @(posedge OPB_Clk);
    #1;
    epb_cs_n = 1'b1;
    epb_oe_n = 1'b1;
    @(posedge OPB_Clk);
    #1;
  endtask

  task automatic epb_write(input logic [2:0] gp, input logic [22:0] addr,
                           input logic [1:0] be_n, input logic [15:0] data);
    run_transfer(1'b0, gp, addr, be_n, data);
    model_write(gp, addr, be_n, data);
  endtask

  task automatic epb_read(input logic [2:0] gp, input logic [22:0] addr, input logic check);
    exp_data = model_read(gp, addr);
    rd_check = check;
    run_transfer(1'b1, gp, addr, 2'b00, 16'h0000);
    rd_check = 1'b0;
  endtask

  // host lets go of cs two cycles into the access
  task automatic epb_abort_write(input logic [2:0] gp, input logic [22:0] addr,
                                 input logic [15:0] data);
    epb_addr_gp = {3'b0, gp};
    epb_addr    = addr;
    epb_be_n    = 2'b00;
    epb_data_i  = data;
    epb_r_w_n   = 1'b0;
    epb_oe_n    = 1'b1;
    epb_cs_n    = 1'b0;
    repeat (2) @(posedge OPB_Clk);
    #1;
    epb_cs_n = 1'b1;
    repeat (3) @(posedge OPB_Clk);
    #1;
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin
    reset       = 1'b1;
    epb_cs_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_oe_n    = 1'b1;
    epb_be_n    = 2'b11;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    exp_data    = '0;
    rd_check    = 1'b0;
    data_errs   = 0;
    rdy_errs    = 0;
    seed        = 42398;
    test_name   = "reset";
    for (int i = 0; i < 2 * `EPB_OPB_REG_COUNT; i++) reg_model[i] = 16'h0000;
    reg_model[0] = 16'(`EPB_OPB_ID >> 16);
    reg_model[1] = 16'(`EPB_OPB_ID);

    repeat (10) @(posedge OPB_Clk);
    #1;
    reset = 1'b0;
    // idle bus, no reply expected here
    repeat (5) @(posedge OPB_Clk);
    #1;

    test_name = "ram_halves";
    for (int h = 0; h < 2; h++) begin
      epb_write(`EPB_OPB_GP_RAM, RAM_WORD | 23'(h), 2'b00, next_rand());
      epb_write(`EPB_OPB_GP_RAM, RAM_WORD | 23'(h), 2'b01, next_rand());
      epb_read(`EPB_OPB_GP_RAM, RAM_WORD | 23'(h), 1'b1);
      epb_write(`EPB_OPB_GP_RAM, RAM_WORD | 23'(h), 2'b10, next_rand());
      epb_read(`EPB_OPB_GP_RAM, RAM_WORD | 23'(h), 1'b1);
    end
    epb_read(`EPB_OPB_GP_RAM, RAM_WORD, 1'b1);

    test_name = "reg_rw";
    for (int a = 2; a < 2 * `EPB_OPB_REG_COUNT; a++) begin
      epb_write(`EPB_OPB_GP_REG, 23'(a), 2'b00, next_rand());
    end
    for (int a = 2; a < 2 * `EPB_OPB_REG_COUNT; a++) begin
      epb_read(`EPB_OPB_GP_REG, 23'(a), 1'b1);
    end

    test_name = "id_word";
    epb_read(`EPB_OPB_GP_REG, 23'd0, 1'b1);
    epb_read(`EPB_OPB_GP_REG, 23'd1, 1'b1);
    epb_write(`EPB_OPB_GP_REG, 23'd0, 2'b00, next_rand());
    epb_read(`EPB_OPB_GP_REG, 23'd0, 1'b1);
    epb_read(`EPB_OPB_GP_REG, 23'd1, 1'b1);

    test_name = "unmapped";
    epb_write(GP_UNMAPPED, 23'h000010, 2'b00, next_rand());
    epb_read(GP_UNMAPPED, 23'h000010, 1'b0);

    test_name = "abort";
    epb_abort_write(`EPB_OPB_GP_RAM, RAM_WORD, next_rand());
    epb_read(`EPB_OPB_GP_RAM, RAM_WORD, 1'b1);

    repeat (3) @(posedge OPB_Clk);
    $display("errors: data %0d, handshake %0d, protocol %0d", data_errs, rdy_errs,
             uut.u_assert.fail_cnt);
    if (data_errs == 0 && rdy_errs == 0 && uut.u_assert.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/epb_opb_pkg.sv
rtl/opb_arbiter.sv
rtl/opb_reg_slave.sv
rtl/opb_ram_slave.sv
rtl/epb_opb_bridge.sv
rtl/epb_opb_top.sv
test/epb_opb_assert.sv
test/epb_opb_tb.sv

//--- Bender.yml
package:
  name: epb_opb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/epb_opb_pkg.sv
      - rtl/opb_arbiter.sv
      - rtl/opb_reg_slave.sv
      - rtl/opb_ram_slave.sv
      - rtl/epb_opb_bridge.sv
      - rtl/epb_opb_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/epb_opb_assert.sv
      - test/epb_opb_tb.sv
